/* elevator.f */
building_pkg.sv
control_pkg.sv
lift_ifs.sv
call_latch.sv
call_scheduler.sv
travel_control.sv
door_control.sv
elevator_top.sv
tb_checker.sv
tb_elevator.sv

/* Makefile */
# Verilator build and run of the lift controller testbench
TOP = tb_elevator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f elevator.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* elevator_cases.txt */
// per case: cab up down obstruct nstops, then 8 stop floors (unused ones are 0)
// all values hex, masks have bit 0 for the ground floor
20 00 08 0 2 3 5 0 0 0 0 0 0
42 00 10 1 3 6 4 1 0 0 0 0 0
01 84 01 0 2 0 2 0 0 0 0 0 0
84 00 00 0 2 2 7 0 0 0 0 0 0
01 01 10 0 2 4 0 0 0 0 0 0 0

/* tb_elevator.sv */
// testbench top for the lift controller; reads elevator_cases.txt and runs every case
`default_nettype none
`timescale 1ns/100ps

module tb_elevator;

	localparam int PERIOD = 40;
	localparam int NUM_CASES = 5;
	localparam int CASE_WORDS = 13;
	localparam int TRAVEL_CYCLES = 8;	// engine run between levels
	localparam int DOOR_CYCLES = 5;		// door travel time

	logic clk;
	logic reset;
	logic open_btn;
	logic close_btn;
	logic overload;
	logic sensor_inside;
	logic sensor_up = 1'b0;
	logic sensor_down = 1'b0;
	control_pkg::door_sense_t sensor_door = control_pkg::SENSE_CLOSED;
	building_pkg::floor_mask_t btn_cab;
	building_pkg::floor_mask_t btn_up;
	building_pkg::floor_mask_t btn_down;
	control_pkg::engine_t engine;
	control_pkg::door_cmd_t door;
	logic direction;
	building_pkg::floor_t display;
	building_pkg::floor_mask_t lamp_cab;
	building_pkg::floor_mask_t lamp_up;
	building_pkg::floor_mask_t lamp_down;

	logic [7:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
	integer seed;
	int run_cnt = 0;
	int hold_cnt = 0;
	int door_cnt = 0;
	control_pkg::door_cmd_t last_cmd = control_pkg::DOOR_IDLE;

	elevator_top u_dut (
		.i_clk (clk), .i_reset (reset),
		.i_open_btn (open_btn), .i_close_btn (close_btn), .i_overload (overload),
		.i_sensor_up (sensor_up), .i_sensor_down (sensor_down),
		.i_sensor_inside (sensor_inside), .i_sensor_door (sensor_door),
		.i_btn_cab (btn_cab), .i_btn_hall_up (btn_up), .i_btn_hall_down (btn_down),
		.o_engine (engine), .o_door (door), .o_direction (direction),
		.o_level_display (display),
		.o_lamp_cab (lamp_cab), .o_lamp_up (lamp_up), .o_lamp_down (lamp_down)
	);

	tb_checker u_check (
		.i_clk (clk), .i_reset (reset),
		.i_btn_cab (btn_cab), .i_btn_up (btn_up), .i_btn_down (btn_down),
		.i_sensor_door (sensor_door), .i_engine (engine), .i_door (door),
		.i_direction (direction), .i_display (display),
		.i_lamp_cab (lamp_cab), .i_lamp_up (lamp_up), .i_lamp_down (lamp_down)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// car and door plant
	always @(negedge clk) begin
		if (reset) begin
			if (hold_cnt > 0) hold_cnt = hold_cnt - 1;
			if (engine != control_pkg::ENGINE_IDLE) begin
				run_cnt = run_cnt + 1;
				if (run_cnt >= TRAVEL_CYCLES) begin	// next level reached
					run_cnt = 0;
					hold_cnt = 2;
				end
			end else begin
				run_cnt = 0;
			end
			sensor_up = (hold_cnt > 0);
			sensor_down = (hold_cnt > 0);
			if (door != last_cmd) door_cnt = 0;
			last_cmd = door;
			if (door != control_pkg::DOOR_IDLE) begin
				door_cnt = door_cnt + 1;
				if (door_cnt < DOOR_CYCLES) sensor_door = control_pkg::SENSE_BETWEEN;
				else if (door == control_pkg::DOOR_OPEN) sensor_door = control_pkg::SENSE_OPEN;
				else sensor_door = control_pkg::SENSE_CLOSED;
			end
		end
	end

	function automatic logic car_idle();
		return engine == control_pkg::ENGINE_IDLE && door == control_pkg::DOOR_IDLE &&
		       sensor_door == control_pkg::SENSE_CLOSED &&
		       (lamp_cab | lamp_up | lamp_down) == '0;
	endfunction

	initial begin
		int base;
		int cnt;
		int close_at;
		int inside_cnt;
		logic obst_done;
		seed = 32'h16aa7a2e;
		reset = 1'b0;
		open_btn = 1'b0;
		close_btn = 1'b0;
		overload = 1'b0;
		sensor_inside = 1'b0;
		btn_cab = '0;
		btn_up = '0;
		btn_down = '0;
		$readmemh("elevator_cases.txt", case_mem);
		repeat (16) @(negedge clk);
		reset = 1'b1;
		for (int c = 0; c < NUM_CASES; c++) begin
			base = c * CASE_WORDS;
			for (int s = 0; s < int'(case_mem[base+4]); s++) begin
				u_check.push_expected(building_pkg::floor_t'(case_mem[base+5+s]));
			end
			if (case_mem[base+3] != 8'h00) u_check.expect_reopen();
			close_at = int'({$random(seed)} % 120);
			@(negedge clk);
			btn_cab = case_mem[base];
			btn_up = case_mem[base+1];
			btn_down = case_mem[base+2];
			@(negedge clk);
			btn_cab = '0;
			btn_up = '0;
			btn_down = '0;
			cnt = 0;
			inside_cnt = 0;
			obst_done = 1'b0;
			while (cnt < 3 || !car_idle()) begin
				@(negedge clk);
				cnt++;
				close_btn = (cnt == close_at);
				if (inside_cnt > 0) inside_cnt--;
				if (case_mem[base+3] != 8'h00 && !obst_done && door == control_pkg::DOOR_CLOSE) begin
					inside_cnt = 3;	// someone steps into the first closing
					obst_done = 1'b1;
				end
				sensor_inside = (inside_cnt > 0);
			end
			close_btn = 1'b0;
			sensor_inside = 1'b0;
			u_check.end_case();
		end
		@(negedge clk);
		$display("errors: %0d value, %0d order, %0d other",
		         u_check.value_errors, u_check.order_errors, u_check.other_errors);
		if (u_check.value_errors + u_check.order_errors + u_check.other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog sized from the case count
	initial begin
		repeat (NUM_CASES * 2000) @(posedge clk);
		$display("watchdog: the cases did not finish within %0d cycles", NUM_CASES * 2000);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_checker.sv */
// testbench checker; watches the lift DUT ports and counts rule and stop-order errors
`default_nettype none
`timescale 1ns/100ps

module tb_checker (
	input  wire                            i_clk,
	input  wire                            i_reset,
	input  wire building_pkg::floor_mask_t i_btn_cab,
	input  wire building_pkg::floor_mask_t i_btn_up,
	input  wire building_pkg::floor_mask_t i_btn_down,
	input  wire control_pkg::door_sense_t  i_sensor_door,
	input  wire control_pkg::engine_t      i_engine,
	input  wire control_pkg::door_cmd_t    i_door,
	input  wire                            i_direction,
	input  wire building_pkg::floor_t      i_display,
	input  wire building_pkg::floor_mask_t i_lamp_cab,
	input  wire building_pkg::floor_mask_t i_lamp_up,
	input  wire building_pkg::floor_mask_t i_lamp_down
);

	int value_errors = 0;
	int order_errors = 0;
	int other_errors = 0;
	building_pkg::floor_t expected_q[$];	// door-opening floors still to come
	building_pkg::floor_mask_t want_cab = '0;
	building_pkg::floor_mask_t want_up = '0;
	building_pkg::floor_mask_t want_down = '0;
	control_pkg::door_cmd_t prev_door = control_pkg::DOOR_IDLE;
	control_pkg::engine_t prev_engine = control_pkg::ENGINE_IDLE;
	building_pkg::floor_t prev_display = '0;
	building_pkg::floor_t door_floor = '0;
	building_pkg::floor_t next_floor;
	logic reset_checked = 1'b0;
	logic clear_due = 1'b0;
	logic reopen_expected = 1'b0;
	logic reopen_seen = 1'b0;

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED at %0t: %s expected %0h got %0h",
			         $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic push_expected(input building_pkg::floor_t f);
		expected_q.push_back(f);
	endtask

	task automatic expect_reopen();
		reopen_expected = 1'b1;
	endtask

	task automatic end_case();
		if (expected_q.size() != 0) begin
			$display("stop order: %0d expected stop(s) never happened", expected_q.size());
			order_errors++;
			expected_q.delete();
		end
		if (reopen_expected && !reopen_seen) begin
			$display("obstruction during closing did not reopen the doors");
			other_errors++;
		end
		reopen_expected = 1'b0;
		reopen_seen = 1'b0;
	endtask

	always @(posedge i_clk) begin
		if (i_reset) begin
			if (!reset_checked) begin	// first cycle out of reset
				check_value("o_engine", 0, int'(i_engine));
				check_value("o_door", 0, int'(i_door));
				check_value("o_direction", 0, int'(i_direction));
				check_value("o_level_display", 0, int'(i_display));
				check_value("o_lamp_cab", 0, int'(i_lamp_cab));
				check_value("o_lamp_up", 0, int'(i_lamp_up));
				check_value("o_lamp_down", 0, int'(i_lamp_down));
				reset_checked = 1'b1;
			end
			// presses of the last cycle must show now
			check_value("o_lamp_cab", int'(want_cab), int'(i_lamp_cab & want_cab));
			check_value("o_lamp_up", int'(want_up), int'(i_lamp_up & want_up));
			check_value("o_lamp_down", int'(want_down), int'(i_lamp_down & want_down));
			check_value("o_lamp_up[7]", 0, int'(i_lamp_up[7]));
			check_value("o_lamp_down[0]", 0, int'(i_lamp_down[0]));
			want_cab = i_btn_cab;
			want_up = i_btn_up & 8'h7f;	// no up call at the top floor
			want_down = i_btn_down & 8'hfe;
			if (clear_due) begin
				check_value("o_lamp_cab", 0, int'(i_lamp_cab[door_floor]));
				check_value("o_lamp_up", 0, int'(i_lamp_up[door_floor]));
				check_value("o_lamp_down", 0, int'(i_lamp_down[door_floor]));
				clear_due = 1'b0;
			end
			if (i_door == control_pkg::DOOR_OPEN && prev_door == control_pkg::DOOR_IDLE) begin
				door_floor = i_display;
				clear_due = 1'b1;
				if (expected_q.size() == 0) begin
					$display("doors opened at floor %0d with no stop expected", i_display);
					order_errors++;
				end else begin
					next_floor = expected_q.pop_front();
					if (next_floor != i_display) begin
						$display("CHECK FAILED at %0t: o_level_display expected %0d got %0d",
						         $time, next_floor, i_display);
						order_errors++;
					end
				end
			end
			if (i_door == control_pkg::DOOR_OPEN && prev_door == control_pkg::DOOR_CLOSE) begin
				reopen_seen = 1'b1;
				check_value("o_level_display", int'(door_floor), int'(i_display));
			end
			if (i_engine != control_pkg::ENGINE_IDLE) begin
				if (i_sensor_door != control_pkg::SENSE_CLOSED ||
				    i_door != control_pkg::DOOR_IDLE) begin
					$display("engine running at %0t while the doors are not closed", $time);
					other_errors++;
				end
				check_value("o_direction", int'(i_engine == control_pkg::ENGINE_UP),
				            int'(i_direction));
			end
			if (i_display != prev_display) begin	// one floor in the engine's direction
				if (prev_engine == control_pkg::ENGINE_UP) begin
					check_value("o_level_display", int'(prev_display) + 1, int'(i_display));
				end else if (prev_engine == control_pkg::ENGINE_DOWN) begin
					check_value("o_level_display", int'(prev_display) - 1, int'(i_display));
				end else begin
					check_value("o_level_display", int'(prev_display), int'(i_display));
				end
			end
			prev_door = i_door;
			prev_engine = i_engine;
			prev_display = i_display;
		end
	end

endmodule

`default_nettype wire

/* elevator_top.sv */
// lift controller top level with plain ports; instantiate this as the DUT
`default_nettype none
`timescale 1ns/100ps

module elevator_top (
	input  wire                           i_clk,
	input  wire                           i_reset,
	input  wire                           i_open_btn,
	input  wire                           i_close_btn,
	input  wire                           i_overload,
	input  wire                           i_sensor_up,
	input  wire                           i_sensor_down,
	input  wire                           i_sensor_inside,
	input  wire control_pkg::door_sense_t i_sensor_door,
	input  wire building_pkg::floor_mask_t i_btn_cab,
	input  wire building_pkg::floor_mask_t i_btn_hall_up,
	input  wire building_pkg::floor_mask_t i_btn_hall_down,
	output control_pkg::engine_t          o_engine,
	output control_pkg::door_cmd_t        o_door,
	output logic                          o_direction,
	output building_pkg::floor_t          o_level_display,
	output building_pkg::floor_mask_t     o_lamp_cab,
	output building_pkg::floor_mask_t     o_lamp_up,
	output building_pkg::floor_mask_t     o_lamp_down
);

	logic door_start;
	logic door_done;

	call_bus_if u_calls ();
	dispatch_if u_disp ();

	for (genvar f = 0; f < building_pkg::NUM_FLOORS; f++) begin : g_floor
		call_latch #(
			.FLOOR_INDEX (f)
		) u_latch (
			.i_clk        (i_clk),
			.i_reset      (i_reset),
			.i_cab_press  (i_btn_cab[f]),
			.i_up_press   (i_btn_hall_up[f]),
			.i_down_press (i_btn_hall_down[f]),
			.calls        (u_calls)
		);
	end

	call_scheduler u_sched (
		.calls (u_calls),
		.disp  (u_disp)
	);

	travel_control u_travel (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_sensor_up   (i_sensor_up),
		.i_sensor_down (i_sensor_down),
		.i_door_done   (door_done),
		.o_door_start  (door_start),
		.o_engine      (o_engine),
		.o_direction   (o_direction),
		.disp          (u_disp),
		.calls         (u_calls)
	);

	door_control u_door (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_start         (door_start),
		.i_sensor_door   (i_sensor_door),
		.i_sensor_inside (i_sensor_inside),
		.i_overload      (i_overload),
		.i_open_btn      (i_open_btn),
		.i_close_btn     (i_close_btn),
		.o_door          (o_door),
		.o_done          (door_done)
	);

	assign o_level_display = u_disp.floor;
	assign o_lamp_cab      = u_calls.cab;	// lamps follow the latched calls
	assign o_lamp_up       = u_calls.hall_up;
	assign o_lamp_down     = u_calls.hall_down;

endmodule

`default_nettype wire

/* door_control.sv */
// door FSM: open, dwell, close, with reopen on obstruction and early close on button
`default_nettype none
`timescale 1ns/100ps

module door_control (
	input  wire                       i_clk,
	input  wire                       i_reset,
	input  wire                       i_start,
	input  wire control_pkg::door_sense_t i_sensor_door,
	input  wire                       i_sensor_inside,
	input  wire                       i_overload,
	input  wire                       i_open_btn,
	input  wire                       i_close_btn,
	output control_pkg::door_cmd_t    o_door,
	output logic                      o_done
);

	control_pkg::door_state_t state_q;
	control_pkg::dwell_count_t dwell_q;
	logic reopen;

	assign reopen = i_sensor_inside | i_overload | i_open_btn;

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			state_q <= control_pkg::DOOR_CLOSED;
			dwell_q <= '0;
			o_door  <= control_pkg::DOOR_IDLE;
			o_done  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state_q)
				control_pkg::DOOR_CLOSED: begin
					if (i_start) begin
						state_q <= control_pkg::DOOR_OPENING;
						o_door  <= control_pkg::DOOR_OPEN;
					end
				end
				control_pkg::DOOR_OPENING: begin
					if (i_sensor_door == control_pkg::SENSE_OPEN) begin
						state_q <= control_pkg::DOOR_DWELL;
						o_door  <= control_pkg::DOOR_IDLE;
						dwell_q <= '0;
					end
				end
				control_pkg::DOOR_DWELL: begin
					if (i_close_btn ||
					    dwell_q == control_pkg::dwell_count_t'(control_pkg::DWELL_CYCLES - 1)) begin
						state_q <= control_pkg::DOOR_CLOSING;
						o_door  <= control_pkg::DOOR_CLOSE;
					end else begin
						dwell_q <= dwell_q + 1'b1;
					end
				end
				control_pkg::DOOR_CLOSING: begin
					if (reopen) begin	// someone in the way
						state_q <= control_pkg::DOOR_OPENING;
						o_door  <= control_pkg::DOOR_OPEN;
					end else if (i_sensor_door == control_pkg::SENSE_CLOSED) begin
						state_q <= control_pkg::DOOR_CLOSED;
						o_door  <= control_pkg::DOOR_IDLE;
						o_done  <= 1'b1;	// travel may move again
					end
				end
				default: begin
					state_q <= control_pkg::DOOR_CLOSED;
					o_door  <= control_pkg::DOOR_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* travel_control.sv */
// travel FSM: floor counter, sweep direction, engine drive and door cycle start
`default_nettype none
`timescale 1ns/100ps

module travel_control (
	input  wire                    i_clk,
	input  wire                    i_reset,
	input  wire                    i_sensor_up,
	input  wire                    i_sensor_down,
	input  wire                    i_door_done,
	output logic                   o_door_start,
	output control_pkg::engine_t   o_engine,
	output logic                   o_direction,
	dispatch_if.travel             disp,
	call_bus_if.travel             calls
);

	control_pkg::travel_state_t state_q;
	building_pkg::floor_t floor_q;
	logic dir_q;
	logic reached_q;	// both level sensors, last cycle
	logic arrive_q;		// floor counter stepped last cycle
	logic reach_edge;
	logic ahead;
	logic behind;
	logic stop_now;
	logic parked;
	logic moving;

	assign parked     = (state_q == control_pkg::TRAVEL_PARKED);
	assign moving     = (state_q == control_pkg::TRAVEL_MOVING);
	assign reach_edge = i_sensor_up & i_sensor_down & ~reached_q;
	assign ahead      = dir_q ? disp.calls_above : disp.calls_below;
	assign behind     = dir_q ? disp.calls_below : disp.calls_above;

	// judged on the new floor, so the engine drops in the same cycle as the display step
	assign stop_now = moving & arrive_q & (disp.stop_here | ~ahead);

	assign o_door_start = disp.stop_here & (parked | (moving & arrive_q));

	always_comb begin
		o_engine = control_pkg::ENGINE_IDLE;
		if (moving && !stop_now) begin
			o_engine = dir_q ? control_pkg::ENGINE_UP : control_pkg::ENGINE_DOWN;
		end
	end

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			state_q   <= control_pkg::TRAVEL_PARKED;
			floor_q   <= '0;	// car starts at ground floor
			dir_q     <= 1'b0;
			reached_q <= 1'b0;
			arrive_q  <= 1'b0;
		end else begin
			reached_q <= i_sensor_up & i_sensor_down;
			arrive_q  <= 1'b0;
			case (state_q)
				control_pkg::TRAVEL_PARKED: begin
					if (disp.stop_here) begin
						state_q <= control_pkg::TRAVEL_DOORS;
					end else if (ahead) begin	// keep sweeping
						state_q <= control_pkg::TRAVEL_MOVING;
					end else if (behind) begin	// reverse
						dir_q   <= ~dir_q;
						state_q <= control_pkg::TRAVEL_MOVING;
					end
				end
				control_pkg::TRAVEL_MOVING: begin
					if (stop_now) begin
						state_q <= disp.stop_here ? control_pkg::TRAVEL_DOORS
						                          : control_pkg::TRAVEL_PARKED;
					end else if (reach_edge) begin
						floor_q  <= dir_q ? floor_q + 1'b1 : floor_q - 1'b1;
						arrive_q <= 1'b1;
					end
				end
				control_pkg::TRAVEL_DOORS: begin
					if (i_door_done) begin
						state_q <= control_pkg::TRAVEL_PARKED;
					end
				end
				default: state_q <= control_pkg::TRAVEL_PARKED;
			endcase
		end
	end

	// current floor held in service for the whole door cycle
	assign calls.serve = (state_q == control_pkg::TRAVEL_DOORS)
	                   ? building_pkg::floor_mask_t'(1) << floor_q : '0;

	assign disp.floor     = floor_q;
	assign disp.direction = dir_q;
	assign o_direction    = dir_q;

endmodule

`default_nettype wire

/* call_scheduler.sv */
// reduces pending calls to stop-here, calls-above and calls-below for the current floor
`default_nettype none
`timescale 1ns/100ps

module call_scheduler (
	call_bus_if.sched  calls,
	dispatch_if.sched  disp
);

	building_pkg::floor_mask_t pending;
	logic above;
	logic below;

	// direction of the hall call does not matter, any call stops the car
	assign pending = calls.cab | calls.hall_up | calls.hall_down;

	always_comb begin
		above = 1'b0;
		below = 1'b0;
		for (int i = 0; i < building_pkg::NUM_FLOORS; i++) begin
			if (i > int'(disp.floor)) begin
				above = above | pending[i];
			end
			if (i < int'(disp.floor)) begin
				below = below | pending[i];
			end
		end
	end

	assign disp.stop_here   = pending[disp.floor];
	assign disp.calls_above = above;
	assign disp.calls_below = below;

endmodule

`default_nettype wire

/* call_latch.sv */
// cab, hall-up and hall-down call flags of one floor; one instance per floor
`default_nettype none
`timescale 1ns/100ps

module call_latch #(
	parameter int FLOOR_INDEX = 0
) (
	input  wire        i_clk,
	input  wire        i_reset,
	input  wire        i_cab_press,
	input  wire        i_up_press,
	input  wire        i_down_press,
	call_bus_if.latch  calls
);

	logic cab_q;
	logic up_q;
	logic down_q;
	logic served;

	assign served = calls.serve[FLOOR_INDEX];

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (!i_reset) begin
			cab_q  <= 1'b0;
			up_q   <= 1'b0;
			down_q <= 1'b0;
		end else if (served) begin	// doors cycling here, presses ignored
			cab_q  <= 1'b0;
			up_q   <= 1'b0;
			down_q <= 1'b0;
		end else begin
			cab_q  <= cab_q | i_cab_press;
			up_q   <= up_q | (i_up_press & (FLOOR_INDEX != building_pkg::NUM_FLOORS - 1));	// no up at top
			down_q <= down_q | (i_down_press & (FLOOR_INDEX != 0));	// no down at ground
		end
	end

	assign calls.cab[FLOOR_INDEX]       = cab_q;
	assign calls.hall_up[FLOOR_INDEX]   = up_q;
	assign calls.hall_down[FLOOR_INDEX] = down_q;

endmodule

`default_nettype wire

/* lift_ifs.sv */
// call bus and dispatch bundles connecting the call latches, scheduler and travel FSM
`default_nettype none
`timescale 1ns/100ps

interface call_bus_if;
	building_pkg::floor_mask_t cab;			// pending cab calls
	building_pkg::floor_mask_t hall_up;		// pending hall calls going up
	building_pkg::floor_mask_t hall_down;	// pending hall calls going down
	building_pkg::floor_mask_t serve;		// floor under service, one-hot

	// each latch drives only its own bit of the masks
	modport latch (output cab, output hall_up, output hall_down, input serve);

	modport sched (input cab, input hall_up, input hall_down);

	modport travel (output serve);
endinterface

interface dispatch_if;
	building_pkg::floor_t floor;	// current car floor
	logic direction;				// 1 up, 0 down
	logic stop_here;				// call pending at current floor
	logic calls_above;
	logic calls_below;

	modport travel (
		output floor, output direction,
		input stop_here, input calls_above, input calls_below
	);

	modport sched (
		input floor,
		output stop_here, output calls_above, output calls_below
	);
endinterface

`default_nettype wire

/* control_pkg.sv */
// engine, door and sensor encodings, door timing and FSM states of the lift controller
`default_nettype none

package control_pkg;

	typedef logic [1:0] engine_t;	// engine command to the motor drive
	localparam engine_t ENGINE_IDLE = 2'd0;
	localparam engine_t ENGINE_DOWN = 2'd1;
	localparam engine_t ENGINE_UP   = 2'd2;

	typedef logic [1:0] door_cmd_t;	// door motor command
	localparam door_cmd_t DOOR_IDLE  = 2'd0;
	localparam door_cmd_t DOOR_OPEN  = 2'd1;
	localparam door_cmd_t DOOR_CLOSE = 2'd2;

	typedef logic [1:0] door_sense_t;	// door position sensor
	localparam door_sense_t SENSE_BETWEEN = 2'd0;
	localparam door_sense_t SENSE_OPEN    = 2'd1;
	localparam door_sense_t SENSE_CLOSED  = 2'd2;

	localparam int DWELL_CYCLES = 10;	// doors held open
	typedef logic [$clog2(DWELL_CYCLES)-1:0] dwell_count_t;

	typedef enum logic [1:0] {TRAVEL_PARKED, TRAVEL_MOVING, TRAVEL_DOORS} travel_state_t;

	typedef enum logic [1:0] {DOOR_CLOSED, DOOR_OPENING, DOOR_DWELL, DOOR_CLOSING} door_state_t;

endpackage

`default_nettype wire

/* building_pkg.sv */
// building geometry shared by the lift RTL and testbench; reference by scoped names
`default_nettype none

package building_pkg;

	localparam int NUM_FLOORS = 8;	// floors 0 .. 7

	// floor index, also the level display value
	typedef logic [$clog2(NUM_FLOORS)-1:0] floor_t;

	// one bit per floor, bit 0 is the ground floor
	typedef logic [NUM_FLOORS-1:0] floor_mask_t;

endpackage

`default_nettype wire
